// ==== include/mpmem_cfg.svh ====
`ifndef MPMEM_CFG_SVH
`define MPMEM_CFG_SVH

// logical memory
`define MPMEM_WIDTH   16
`define MPMEM_BITADDR 8

// banking, low address bits pick the bank
`define MPMEM_NUMVBNK 4
`define MPMEM_BITVBNK 2
`define MPMEM_BITVROW 6

// physical row packing
`define MPMEM_NUMWRDS 4
`define MPMEM_BITWRDS 2
`define MPMEM_BITSROW 4
`define MPMEM_PHYWDTH (`MPMEM_NUMWRDS * `MPMEM_WIDTH)

// refresh groups, taken from the top bits of the physical row
`define MPMEM_NUMRBNK 4
`define MPMEM_BITRBNK 2

`define MPMEM_RD_LAT  3

`endif

// ==== rtl/mpmem_pkg.sv ====
`default_nettype none
`include "mpmem_cfg.svh"

package mpmem_pkg;

  typedef logic [`MPMEM_WIDTH-1:0]   data_t;
  typedef logic [`MPMEM_BITADDR-1:0] addr_t;
  typedef logic [`MPMEM_BITVBNK-1:0] vbnk_t;
  typedef logic [`MPMEM_BITVROW-1:0] vrow_t;
  typedef logic [`MPMEM_BITSROW-1:0] srow_t;
  typedef logic [`MPMEM_BITWRDS-1:0] wrd_t;
  typedef logic [`MPMEM_PHYWDTH-1:0] phy_t;   // row data and bit-write mask.
  typedef logic [`MPMEM_BITRBNK-1:0] rbnk_t;

  typedef enum logic {
    INIT,
    RUN
  } core_state_e;

  // one access per bank per cycle.
  typedef struct packed {
    logic  read;
    logic  write;
    vrow_t vrow;
    data_t data;
    logic  init;    // clear the whole physical row.
  } bank_req_t;

endpackage

`default_nettype wire

// ==== rtl/mpmem_1r1w_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mpmem_cfg.svh"

module mpmem_1r1w_core (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 read,
  input  logic                 write,
  input  mpmem_pkg::addr_t     addr_rd,
  input  mpmem_pkg::addr_t     addr_wr,
  input  mpmem_pkg::data_t     din,
  output logic                 ready,
  output logic                 rd_vld,
  output mpmem_pkg::data_t     rd_dout,
  output mpmem_pkg::bank_req_t bank_req [`MPMEM_NUMVBNK],
  input  mpmem_pkg::data_t     bank_data [`MPMEM_NUMVBNK]
);

  localparam int NUMVROW = 1 << `MPMEM_BITVROW;

  mpmem_pkg::core_state_e state;
  logic                   init_on;
  mpmem_pkg::srow_t       init_row;

  logic                   rd_q;
  logic                   wr_q;
  mpmem_pkg::addr_t       ard_q;
  mpmem_pkg::addr_t       awr_q;
  mpmem_pkg::data_t       din_q;

  mpmem_pkg::vbnk_t       rd_bnk;
  mpmem_pkg::vbnk_t       wr_bnk;
  mpmem_pkg::vrow_t       rd_row;
  mpmem_pkg::vrow_t       wr_row;

  logic [NUMVROW-1:0]     c_vld;
  mpmem_pkg::vbnk_t       c_tag [NUMVROW];
  mpmem_pkg::data_t       c_dat [NUMVROW];

  logic                   rd_hit;
  logic                   same_bnk;
  logic                   evict;

  logic                   rd_v2;
  logic                   rd_v3;
  logic                   hit2;
  logic                   hit3;
  mpmem_pkg::vbnk_t       bnk2;
  mpmem_pkg::vbnk_t       bnk3;
  mpmem_pkg::data_t       cw2;
  mpmem_pkg::data_t       cw3;

  // init sweep, one physical row of every bank per cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mpmem_pkg::INIT;
      init_on  <= 1'b0;
      init_row <= '0;
    end else if (state == mpmem_pkg::INIT) begin
      init_on <= 1'b1;
      if (init_on) begin
        init_row <= init_row + 1'b1;
        if (init_row == '1) begin
          init_on <= 1'b0;
          state   <= mpmem_pkg::RUN;
        end
      end
    end
  end

  assign ready = (state == mpmem_pkg::RUN);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
    end else begin
      rd_q <= read && ready;    // requests before ready are dropped.
      wr_q <= write && ready;
    end
  end

  always_ff @(posedge clk) begin
    ard_q <= addr_rd;
    awr_q <= addr_wr;
    din_q <= din;
  end

  assign rd_bnk = ard_q[`MPMEM_BITVBNK-1:0];
  assign wr_bnk = awr_q[`MPMEM_BITVBNK-1:0];
  assign rd_row = ard_q[`MPMEM_BITADDR-1:`MPMEM_BITVBNK];
  assign wr_row = awr_q[`MPMEM_BITADDR-1:`MPMEM_BITVBNK];

  assign rd_hit   = rd_q && c_vld[rd_row] && (c_tag[rd_row] == rd_bnk);
  assign same_bnk = rd_q && wr_q && (rd_bnk == wr_bnk);
  // the evicted word's bank differs from the read bank, so it is idle.
  assign evict    = same_bnk && c_vld[wr_row] && (c_tag[wr_row] != wr_bnk);

  always_comb begin
    for (int b = 0; b < `MPMEM_NUMVBNK; b++) begin
      bank_req[b] = '0;
      if (init_on) begin
        bank_req[b].write = 1'b1;
        bank_req[b].init  = 1'b1;
        bank_req[b].vrow  = {init_row, {`MPMEM_BITWRDS{1'b0}}};
      end else begin
        if (rd_q && !rd_hit && (rd_bnk == mpmem_pkg::vbnk_t'(b))) begin
          bank_req[b].read = 1'b1;
          bank_req[b].vrow = rd_row;
        end
        if (wr_q && !same_bnk && (wr_bnk == mpmem_pkg::vbnk_t'(b))) begin
          bank_req[b].write = 1'b1;
          bank_req[b].vrow  = wr_row;
          bank_req[b].data  = din_q;
        end
        if (evict && (c_tag[wr_row] == mpmem_pkg::vbnk_t'(b))) begin
          bank_req[b].write = 1'b1;   // write back the old cache word.
          bank_req[b].vrow  = wr_row;
          bank_req[b].data  = c_dat[wr_row];
        end
      end
    end
  end

  // write cache, one entry per virtual row.
  always_ff @(posedge clk) begin
    if (rst) begin
      c_vld <= '0;
    end else if (wr_q) begin
      if (same_bnk) begin
        c_vld[wr_row] <= 1'b1;
      end else if (c_vld[wr_row] && (c_tag[wr_row] == wr_bnk)) begin
        c_vld[wr_row] <= 1'b0;    // bank now has the newer word.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_q && same_bnk) begin
      c_tag[wr_row] <= wr_bnk;
      c_dat[wr_row] <= din_q;
    end
  end

  // read pipeline, cache hits wait for the bank return slot.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_v2  <= 1'b0;
      rd_v3  <= 1'b0;
      rd_vld <= 1'b0;
    end else begin
      rd_v2  <= rd_q;
      rd_v3  <= rd_v2;
      rd_vld <= rd_v3;
    end
  end

  always_ff @(posedge clk) begin
    hit2    <= rd_hit;
    bnk2    <= rd_bnk;
    cw2     <= c_dat[rd_row];   // value before this cycle's update.
    hit3    <= hit2;
    bnk3    <= bnk2;
    cw3     <= cw2;
    rd_dout <= hit3 ? cw3 : bank_data[bnk3];
  end

endmodule

`default_nettype wire

// ==== rtl/row_align.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mpmem_cfg.svh"

module row_align (
  input  logic                 clk,
  input  logic                 rst,
  input  mpmem_pkg::bank_req_t req,
  output mpmem_pkg::data_t     dout_word,
  output logic                 mem_read,
  output logic                 mem_write,
  output mpmem_pkg::srow_t     mem_addr,
  output mpmem_pkg::phy_t      mem_bw,
  output mpmem_pkg::phy_t      mem_din,
  input  mpmem_pkg::phy_t      mem_dout
);

  mpmem_pkg::wrd_t wrd;
  mpmem_pkg::wrd_t wrd_q;
  logic            rd_q;

  assign wrd       = req.vrow[`MPMEM_BITWRDS-1:0];
  assign mem_read  = req.read;
  assign mem_write = req.write;
  assign mem_addr  = req.vrow[`MPMEM_BITVROW-1:`MPMEM_BITWRDS];

  always_comb begin
    if (req.init) begin
      mem_din = '0;
      mem_bw  = '1;       // whole row.
    end else begin
      mem_din = {`MPMEM_NUMWRDS{req.data}};
      mem_bw  = '0;
      mem_bw[wrd*`MPMEM_WIDTH +: `MPMEM_WIDTH] = '1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= req.read;
    end
  end

  always_ff @(posedge clk) begin
    if (req.read) begin
      wrd_q <= wrd;
    end
    if (rd_q) begin
      dout_word <= mem_dout[wrd_q*`MPMEM_WIDTH +: `MPMEM_WIDTH];  // ram output is a cycle old.
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bank_refresh.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mpmem_cfg.svh"

module bank_refresh (
  input  logic             clk,
  input  logic             rst,
  input  logic             pref,
  input  logic             pacc,
  input  mpmem_pkg::rbnk_t pacgrp,
  output logic             prefr,
  output mpmem_pkg::rbnk_t prfgrp
);

  logic [2:0]       pend;
  mpmem_pkg::rbnk_t grp;
  logic             blocked;

  // an access to the group due for refresh holds it back.
  assign blocked = pacc && (pacgrp == grp);
  assign prefr   = (pend != '0) && !blocked;
  assign prfgrp  = grp;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend <= '0;
      grp  <= '0;
    end else begin
      case ({pref, prefr})
        2'b10:   pend <= pend + 1'b1;
        2'b01:   pend <= pend - 1'b1;
        default: pend <= pend;    // new pulse and issue cancel out.
      endcase
      if (prefr) begin
        grp <= grp + 1'b1;        // wraps over all groups.
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mpmem_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mpmem_cfg.svh"

module mpmem_top (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       refr,
  input  logic                                       read,
  input  logic                                       write,
  input  mpmem_pkg::addr_t                           addr_rd,
  input  mpmem_pkg::addr_t                           addr_wr,
  input  mpmem_pkg::data_t                           din,
  output logic                                       ready,
  output logic                                       rd_vld,
  output mpmem_pkg::data_t                           rd_dout,
  output wire [`MPMEM_NUMVBNK-1:0]                   bank_read,
  output wire [`MPMEM_NUMVBNK-1:0]                   bank_write,
  output wire mpmem_pkg::srow_t [`MPMEM_NUMVBNK-1:0] bank_addr,
  output wire mpmem_pkg::phy_t  [`MPMEM_NUMVBNK-1:0] bank_bw,
  output wire mpmem_pkg::phy_t  [`MPMEM_NUMVBNK-1:0] bank_din,
  output wire [`MPMEM_NUMVBNK-1:0]                   bank_refr,
  output wire mpmem_pkg::rbnk_t [`MPMEM_NUMVBNK-1:0] bank_rgrp,
  input  mpmem_pkg::phy_t [`MPMEM_NUMVBNK-1:0]       bank_dout
);

  mpmem_pkg::bank_req_t breq [`MPMEM_NUMVBNK];
  mpmem_pkg::data_t     bdata [`MPMEM_NUMVBNK];
  logic                 refr_on;

  assign refr_on = refr && ready;   // pulses during init are dropped.

  mpmem_1r1w_core u_core (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .write     (write),
    .addr_rd   (addr_rd),
    .addr_wr   (addr_wr),
    .din       (din),
    .ready     (ready),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .bank_req  (breq),
    .bank_data (bdata)
  );

  for (genvar b = 0; b < `MPMEM_NUMVBNK; b++) begin : g_bank
    mpmem_pkg::rbnk_t acc_grp;

    assign acc_grp = bank_addr[b][`MPMEM_BITSROW-1 -: `MPMEM_BITRBNK];

    row_align u_align (
      .clk       (clk),
      .rst       (rst),
      .req       (breq[b]),
      .dout_word (bdata[b]),
      .mem_read  (bank_read[b]),
      .mem_write (bank_write[b]),
      .mem_addr  (bank_addr[b]),
      .mem_bw    (bank_bw[b]),
      .mem_din   (bank_din[b]),
      .mem_dout  (bank_dout[b])
    );

    bank_refresh u_refr (
      .clk    (clk),
      .rst    (rst),
      .pref   (refr_on),
      .pacc   (bank_read[b] || bank_write[b]),
      .pacgrp (acc_grp),
      .prefr  (bank_refr[b]),
      .prfgrp (bank_rgrp[b])
    );
  end

endmodule

`default_nettype wire

// ==== bench/bank_ram_model.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mpmem_cfg.svh"

module bank_ram_model (
  input  logic             clk,
  input  logic             read,
  input  logic             write,
  input  mpmem_pkg::srow_t addr,
  input  mpmem_pkg::phy_t  bw,
  input  mpmem_pkg::phy_t  din,
  output mpmem_pkg::phy_t  dout
);

  localparam int NUMROWS = 1 << `MPMEM_BITSROW;

  mpmem_pkg::phy_t mem [NUMROWS];   // starts unknown, the init sweep clears it.

  always @(posedge clk) begin
    if (write) begin
      mem[addr] <= (mem[addr] & ~bw) | (din & bw);
    end
    if (read) begin
      dout <= mem[addr];            // registered read.
    end
  end

endmodule

`default_nettype wire

// ==== bench/mpmem_assert.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mpmem_cfg.svh"

module mpmem_assert (
  input logic                                   clk,
  input logic                                   rst,
  input logic                                   read,
  input logic                                   ready,
  input logic                                   rd_vld,
  input logic [`MPMEM_NUMVBNK-1:0]              bank_read,
  input logic [`MPMEM_NUMVBNK-1:0]              bank_write,
  input logic [`MPMEM_NUMVBNK-1:0]              bank_refr,
  input mpmem_pkg::srow_t [`MPMEM_NUMVBNK-1:0]  bank_addr,
  input mpmem_pkg::rbnk_t [`MPMEM_NUMVBNK-1:0]  bank_rgrp
);

  int unsigned fail_cnt = 0;

  a_rst_quiet: assert property (@(posedge clk)
    rst ##1 rst |-> !rd_vld && bank_read == '0 && bank_write == '0 && bank_refr == '0)
    else begin
      $error("bank or read activity during reset");
      fail_cnt++;
    end

  a_one_op: assert property (@(posedge clk) disable iff (rst)
    (bank_read & bank_write) == '0)
    else begin
      $error("bank read and write in the same cycle");
      fail_cnt++;
    end

  // rd_vld rises at the third edge, so the sampled value shows it one tick later.
  a_rd_lat: assert property (@(posedge clk) disable iff (rst)
    rd_vld == $past(read && ready, `MPMEM_RD_LAT + 1))
    else begin
      $error("rd_vld out of step with accepted reads");
      fail_cnt++;
    end

  a_init_only: assert property (@(posedge clk) disable iff (rst)
    !ready |-> bank_read == '0 && bank_refr == '0 && (bank_write == '0 || bank_write == '1))
    else begin
      $error("bank access before ready other than the init sweep");
      fail_cnt++;
    end

  for (genvar b = 0; b < `MPMEM_NUMVBNK; b++) begin : g_bank
    a_refr_grp: assert property (@(posedge clk) disable iff (rst)
      bank_refr[b] |-> !((bank_read[b] || bank_write[b]) &&
        bank_addr[b][`MPMEM_BITSROW-1 -: `MPMEM_BITRBNK] == bank_rgrp[b]))
      else begin
        $error("refresh of the group being accessed");
        fail_cnt++;
      end
  end

endmodule

`default_nettype wire

// ==== bench/mpmem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "mpmem_cfg.svh"

module mpmem_tb;

  localparam int HALF     = 20;
  localparam int NUMADDR  = 1 << `MPMEM_BITADDR;
  localparam int NUMRAND  = 400;
  localparam int NUMDIR   = 40;
  localparam int NUMREFR  = 8;
  localparam int NUMTRANS = NUMADDR + NUMRAND + NUMDIR + NUMREFR;
  localparam int WDOG_CYC = 40 * NUMTRANS + 16 + 20;

  logic                                        clk;
  logic                                        rst;
  logic                                        refr;
  logic                                        read;
  logic                                        write;
  mpmem_pkg::addr_t                            addr_rd;
  mpmem_pkg::addr_t                            addr_wr;
  mpmem_pkg::data_t                            din;
  logic                                        ready;
  logic                                        rd_vld;
  mpmem_pkg::data_t                            rd_dout;
  wire [`MPMEM_NUMVBNK-1:0]                    bank_read;
  wire [`MPMEM_NUMVBNK-1:0]                    bank_write;
  wire [`MPMEM_NUMVBNK-1:0]                    bank_refr;
  wire mpmem_pkg::srow_t [`MPMEM_NUMVBNK-1:0]  bank_addr;
  wire mpmem_pkg::phy_t  [`MPMEM_NUMVBNK-1:0]  bank_bw;
  wire mpmem_pkg::phy_t  [`MPMEM_NUMVBNK-1:0]  bank_din;
  wire mpmem_pkg::phy_t  [`MPMEM_NUMVBNK-1:0]  bank_dout;
  wire mpmem_pkg::rbnk_t [`MPMEM_NUMVBNK-1:0]  bank_rgrp;

  mpmem_pkg::data_t ref_mem [NUMADDR];
  mpmem_pkg::data_t exp_q [$];
  int unsigned      when_q [$];
  int unsigned      cyc;
  string            test_name;
  int unsigned      pulses [`MPMEM_NUMVBNK];
  int unsigned      issued [`MPMEM_NUMVBNK];
  mpmem_pkg::rbnk_t exp_grp [`MPMEM_NUMVBNK];

  mpmem_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .refr       (refr),
    .read       (read),
    .write      (write),
    .addr_rd    (addr_rd),
    .addr_wr    (addr_wr),
    .din        (din),
    .ready      (ready),
    .rd_vld     (rd_vld),
    .rd_dout    (rd_dout),
    .bank_read  (bank_read),
    .bank_write (bank_write),
    .bank_addr  (bank_addr),
    .bank_bw    (bank_bw),
    .bank_din   (bank_din),
    .bank_refr  (bank_refr),
    .bank_rgrp  (bank_rgrp),
    .bank_dout  (bank_dout)
  );

  for (genvar b = 0; b < `MPMEM_NUMVBNK; b++) begin : g_ram
    bank_ram_model u_ram (
      .clk   (clk),
      .read  (bank_read[b]),
      .write (bank_write[b]),
      .addr  (bank_addr[b]),
      .bw    (bank_bw[b]),
      .din   (bank_din[b]),
      .dout  (bank_dout[b])
    );
  end

  bind mpmem_top mpmem_assert u_assert (.*);

  always #HALF clk = ~clk;

  // old word at the read address; the same cycle's write lands after it.
  function automatic mpmem_pkg::data_t ref_access(input mpmem_pkg::addr_t ra,
                                                  input logic wr_en,
                                                  input mpmem_pkg::addr_t wa,
                                                  input mpmem_pkg::data_t wd);
    mpmem_pkg::data_t old;
    old = ref_mem[ra];
    if (wr_en) begin
      ref_mem[wa] = wd;
    end
    return old;
  endfunction

  task automatic report_error(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic drive(input logic rd, input mpmem_pkg::addr_t ra, input logic wr,
                       input mpmem_pkg::addr_t wa, input mpmem_pkg::data_t wd, input logic rf);
    @(posedge clk);
    read    <= rd;
    addr_rd <= ra;
    write   <= wr;
    addr_wr <= wa;
    din     <= wd;
    refr    <= rf;
  endtask

  task automatic drain();
    drive(1'b0, '0, 1'b0, '0, '0, 1'b0);
    repeat (2) @(posedge clk);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);    // lets held-back refreshes go out.
  endtask

  task automatic check_refresh_count();
    for (int b = 0; b < `MPMEM_NUMVBNK; b++) begin
      check_val("refresh count", pulses[b], issued[b]);
    end
  endtask

  always @(posedge clk) begin
    mpmem_pkg::data_t old;
    cyc = cyc + 1;
    if (u_dut.u_assert.fail_cnt != 0) begin
      report_error("a bound assertion on the DUT ports failed");
    end
    if (!rst) begin
      if (rd_vld) begin
        if (exp_q.size() == 0) begin
          report_error("rd_vld high with no read in flight");
        end else begin
          check_val(test_name, exp_q.pop_front(), rd_dout);
          check_val("read latency", `MPMEM_RD_LAT + 1, cyc - when_q.pop_front());
        end
      end
      if (ready && (read || write)) begin
        old = ref_access(addr_rd, write, addr_wr, din);
        if (read) begin
          exp_q.push_back(old);
          when_q.push_back(cyc);
        end
      end
      for (int b = 0; b < `MPMEM_NUMVBNK; b++) begin
        if (bank_refr[b]) begin
          if (issued[b] >= pulses[b]) begin
            report_error("bank refresh issued with no refresh pending");
          end
          check_val("refresh group", exp_grp[b], bank_rgrp[b]);
          if ((bank_read[b] || bank_write[b]) &&
              bank_addr[b][`MPMEM_BITSROW-1 -: `MPMEM_BITRBNK] == bank_rgrp[b]) begin
            report_error("bank refresh collides with an access to its group");
          end
          issued[b]++;
          exp_grp[b]++;               // groups wrap 0 to 3.
        end
        if (refr && ready) begin
          check_val("refresh pending", pulses[b], issued[b]);
          pulses[b]++;
        end
      end
    end
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    report_error("watchdog timeout, the run did not finish");
  end

  initial begin
    int n;
    void'($urandom(96));
    clk       = 1'b0;
    rst       = 1'b1;
    refr      = 1'b0;
    read      = 1'b0;
    write     = 1'b0;
    addr_rd   = '0;
    addr_wr   = '0;
    din       = '0;
    cyc       = 0;
    test_name = "init clear";
    foreach (ref_mem[i]) begin
      ref_mem[i] = '0;
    end
    for (int b = 0; b < `MPMEM_NUMVBNK; b++) begin
      pulses[b]  = 0;
      issued[b]  = 0;
      exp_grp[b] = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    // requests during the init sweep are ignored.
    for (n = 0; n < 4; n++) begin
      drive(1'b1, mpmem_pkg::addr_t'(n), 1'b1, mpmem_pkg::addr_t'(n), 16'hdead, 1'b1);
    end
    drive(1'b0, '0, 1'b0, '0, '0, 1'b0);
    for (n = 5; n < 20 && !ready; n++) begin
      @(negedge clk);
    end
    if (!ready) begin
      report_error("ready did not rise within 20 cycles of reset release");
    end

    for (int a = 0; a < NUMADDR; a++) begin
      drive(1'b1, mpmem_pkg::addr_t'(a), 1'b0, '0, '0, 1'b0);
    end
    drain();

    test_name = "random traffic";
    for (int i = 0; i < NUMRAND; i++) begin
      drive(($urandom % 4) != 0, mpmem_pkg::addr_t'($urandom), ($urandom % 4) != 0,
            mpmem_pkg::addr_t'($urandom), mpmem_pkg::data_t'($urandom), (i % 16) == 0);
    end
    drain();
    check_refresh_count();

    // bank 1 fills the cache, bank 2 on the same rows evicts it.
    test_name = "same bank";
    for (int i = 0; i < 8; i++) begin
      drive(1'b1, mpmem_pkg::addr_t'((i + 8) * `MPMEM_NUMVBNK + 1), 1'b1,
            mpmem_pkg::addr_t'(i * `MPMEM_NUMVBNK + 1), mpmem_pkg::data_t'(16'h3100 + i), 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      drive(1'b1, mpmem_pkg::addr_t'((i + 8) * `MPMEM_NUMVBNK + 2), 1'b1,
            mpmem_pkg::addr_t'(i * `MPMEM_NUMVBNK + 2), mpmem_pkg::data_t'(16'h3200 + i), 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      drive(1'b1, mpmem_pkg::addr_t'(i * `MPMEM_NUMVBNK + 1), 1'b0, '0, '0, 1'b0);
      drive(1'b1, mpmem_pkg::addr_t'(i * `MPMEM_NUMVBNK + 2), 1'b0, '0, '0, 1'b0);
    end
    drain();

    test_name = "read during write";
    drive(1'b0, '0, 1'b1, 8'h5a, 16'h1234, 1'b0);
    drive(1'b1, 8'h5a, 1'b1, 8'h5a, 16'hbeef, 1'b0);
    drive(1'b1, 8'h5a, 1'b0, '0, '0, 1'b0);
    drain();

    test_name = "idle refresh";
    for (int i = 0; i < NUMREFR; i++) begin
      drive(1'b0, '0, 1'b0, '0, '0, 1'b1);
      drive(1'b0, '0, 1'b0, '0, '0, 1'b0);
      repeat (14) @(posedge clk);
    end
    drain();
    check_refresh_count();

    if (u_dut.u_assert.fail_cnt != 0) begin
      $display("%0d assertion failures", u_dut.u_assert.fail_cnt);
      $display("TEST FAILED");
      $fatal(1, "assertions failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
rtl/mpmem_pkg.sv
rtl/mpmem_1r1w_core.sv
rtl/row_align.sv
rtl/bank_refresh.sv
rtl/mpmem_top.sv
bench/bank_ram_model.sv
bench/mpmem_assert.sv
bench/mpmem_tb.sv

// ==== Bender.yml ====
package:
  name: mpmem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/mpmem_pkg.sv
      - rtl/mpmem_1r1w_core.sv
      - rtl/row_align.sv
      - rtl/bank_refresh.sv
      - rtl/mpmem_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/bank_ram_model.sv
      - bench/mpmem_assert.sv
      - bench/mpmem_tb.sv
